// ==== fetch_unit.f ====
common/fetch_pkg.sv
rvc/rvc_expander.sv
logic/parcel_aligner.sv
logic/target_calc.sv
logic/fetch_queue.sv
logic/fetch_ctrl.sv
logic/fetch_unit.sv
sim/imem_model.sv
sim/fetch_unit_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - common/fetch_pkg.sv
  - rvc/rvc_expander.sv
  - logic/parcel_aligner.sv
  - logic/target_calc.sv
  - logic/fetch_queue.sv
  - logic/fetch_ctrl.sv
  - logic/fetch_unit.sv
  - target: test
    files:
      - sim/imem_model.sv
      - sim/fetch_unit_tb.sv

// ==== sim/fetch_unit_tb.sv ====
`timescale 1ns/1ns

module fetch_unit_tb import fetch_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int MEM_WORDS    = 1024;
  localparam int TOTAL_ITEMS  = 47;  // Sum of the item counts of all tests

  logic            clk = 1'b0;
  logic            rst;
  wb_req_t         wb_req;
  wb_rsp_t         wb_rsp;
  logic            predict_taken;
  logic            flush;
  logic [XLEN-1:0] flush_pc;
  logic            out_valid;
  fetch_item_t     out_item;
  logic            out_ready;
  logic            random_ready;
  integer          seed = 32'h30e7_2a3f;
  fetch_item_t     expected [$];

  // c.li x10,5  c.addi x10,1  c.mv x11,x10  c.add x10,x11
  // c.lw x9,4(x8)  c.sw x9,4(x8)  c.slli x10,3  c.sub x8,x9
  logic [15:0] rvc_parcel [8] = '{16'h4515, 16'h0505, 16'h85aa, 16'h952e,
                                  16'h4044, 16'hc044, 16'h050e, 16'h8c05};
  logic [31:0] rvc_instr  [8] = '{32'h00500513, 32'h00150513, 32'h00a005b3, 32'h00b50533,
                                  32'h00442483, 32'h00942223, 32'h00351513, 32'h40940433};

  fetch_unit fetch_unit_i (
    .clk           (clk),
    .rst           (rst),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .predict_taken (predict_taken),
    .flush         (flush),
    .flush_pc      (flush_pc),
    .out_valid     (out_valid),
    .out_item      (out_item),
    .out_ready     (out_ready)
  );

  imem_model #(.WORDS(MEM_WORDS)) imem_model_i (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #20 clk = ~clk;

  // Mostly stalled, so the queue fills up
  always @(posedge clk) begin
    if (random_ready) begin
      out_ready <= ($random(seed) & 15) == 0;
    end
  end

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] want,
                             input string what);
    if (actual !== want) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, want);
      $display("Verification failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic load_word(input logic [XLEN-1:0] addr, input logic [31:0] data);
    imem_model_i.mem[addr[11:2]] = data;
  endtask

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem_model_i.mem[i] = addi_word(5'd0, 5'd0, 12'(i));  // Immediate is the word index
    end
  endtask

  task automatic expect_item(input logic [XLEN-1:0] pc, input logic [31:0] instr,
                             input logic compressed, input logic pred);
    fetch_item_t item;
    item.pc         = pc;
    item.instr      = instr;
    item.compressed = compressed;
    item.pred_taken = pred;
    expected.push_back(item);
  endtask

  task automatic start_at(input logic [XLEN-1:0] pc);
    @(posedge clk);
    flush    <= 1'b1;
    flush_pc <= pc;
    @(posedge clk);
    flush <= 1'b0;
    @(posedge clk);
    check_value(out_valid, 0, "out_valid after flush");
  endtask

  // Compares every transfer against the expected list
  task automatic take_items(input int n);
    fetch_item_t got;
    fetch_item_t want;
    int          taken;
    taken = 0;
    while (taken < n) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        got  = out_item;
        want = expected.pop_front();
        check_value(got.pc, want.pc, "item pc");
        check_value(got.instr, want.instr, "item instruction");
        check_value(got.compressed, want.compressed, "compressed flag");
        check_value(got.pred_taken, want.pred_taken, "predicted flag");
        taken++;
      end
    end
  endtask

  task automatic wait_acks(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clk);
      if (wb_req.cyc && wb_rsp.ack) begin
        seen++;
      end
    end
  endtask

  task automatic plain_stream();
    for (int i = 0; i < 8; i++) begin
      load_word(32'(4 * i), addi_word(5'(i + 1), 5'd0, 12'(100 + i)));
      expect_item(32'(4 * i), addi_word(5'(i + 1), 5'd0, 12'(100 + i)), 1'b0, 1'b0);
    end
    start_at(RESET_PC);
    take_items(8);
  endtask

  task automatic compressed_pairs();
    for (int i = 0; i < 4; i++) begin
      load_word(32'h100 + 32'(4 * i), {rvc_parcel[2*i+1], rvc_parcel[2*i]});
    end
    for (int i = 0; i < 8; i++) begin
      expect_item(32'h100 + 32'(2 * i), rvc_instr[i], 1'b1, 1'b0);
    end
    start_at(32'h100);
    take_items(8);
  endtask

  task automatic straddle_join();
    logic [31:0] wide;
    wide = addi_word(5'd13, 5'd8, 12'h123);
    load_word(32'h200, {wide[15:0], rvc_parcel[0]});
    load_word(32'h204, {rvc_parcel[1], wide[31:16]});
    load_word(32'h208, addi_word(5'd14, 5'd0, 12'd7));
    expect_item(32'h200, rvc_instr[0], 1'b1, 1'b0);
    expect_item(32'h202, wide, 1'b0, 1'b0);  // Joined at the half-word PC
    expect_item(32'h206, rvc_instr[1], 1'b1, 1'b0);
    expect_item(32'h208, addi_word(5'd14, 5'd0, 12'd7), 1'b0, 1'b0);
    start_at(32'h200);
    take_items(4);
  endtask

  task automatic redirect_paths();
    for (int i = 0; i < 8; i++) begin
      load_word(32'h300 + 32'(4 * i), addi_word(5'd1, 5'd0, 12'h3ff));  // Skipped words
    end
    load_word(32'h300, 32'h0100006f);  // jal x0, +16
    load_word(32'h310, 32'h00000463);  // beq x0, x0, +8
    load_word(32'h318, addi_word(5'd15, 5'd0, 12'd1));
    load_word(32'h400, 32'h00000463);
    load_word(32'h404, addi_word(5'd16, 5'd0, 12'd2));
    expect_item(32'h300, 32'h0100006f, 1'b0, 1'b0);
    expect_item(32'h310, 32'h00000463, 1'b0, 1'b1);
    expect_item(32'h318, addi_word(5'd15, 5'd0, 12'd1), 1'b0, 1'b0);
    @(posedge clk);
    predict_taken <= 1'b1;
    start_at(32'h300);
    take_items(3);
    expect_item(32'h400, 32'h00000463, 1'b0, 1'b0);
    expect_item(32'h404, addi_word(5'd16, 5'd0, 12'd2), 1'b0, 1'b0);  // Fall through
    @(posedge clk);
    predict_taken <= 1'b0;
    start_at(32'h400);
    take_items(2);
  endtask

  task automatic backpressure_order();
    for (int i = 0; i < 16; i++) begin
      load_word(32'h500 + 32'(4 * i), addi_word(5'd5, 5'd0, 12'(12'h40 + i)));
      expect_item(32'h500 + 32'(4 * i), addi_word(5'd5, 5'd0, 12'(12'h40 + i)), 1'b0, 1'b0);
    end
    @(posedge clk);
    random_ready <= 1'b1;
    start_at(32'h500);
    take_items(16);
    @(posedge clk);
    random_ready <= 1'b0;
    @(posedge clk);
    out_ready <= 1'b1;
  endtask

  task automatic flush_restart();
    for (int i = 0; i < 8; i++) begin
      load_word(32'h600 + 32'(4 * i), addi_word(5'd6, 5'd0, 12'(12'h60 + i)));
    end
    for (int i = 0; i < 4; i++) begin
      load_word(32'h700 + 32'(4 * i), addi_word(5'd7, 5'd0, 12'(12'h70 + i)));
    end
    expect_item(32'h600, addi_word(5'd6, 5'd0, 12'h60), 1'b0, 1'b0);
    expect_item(32'h604, addi_word(5'd6, 5'd0, 12'h61), 1'b0, 1'b0);
    start_at(32'h600);
    take_items(2);
    out_ready <= 1'b0;  // Older items pile up in the queue
    wait_acks(3);
    for (int i = 0; i < 4; i++) begin
      expect_item(32'h700 + 32'(4 * i), addi_word(5'd7, 5'd0, 12'(12'h70 + i)), 1'b0, 1'b0);
    end
    start_at(32'h700);
    out_ready <= 1'b1;
    take_items(4);
  endtask

  initial begin
    rst           = 1'b1;
    predict_taken = 1'b0;
    flush         = 1'b0;
    flush_pc      = '0;
    out_ready     = 1'b1;
    random_ready  = 1'b0;
    fill_memory();
    repeat (RESET_CYCLES) @(posedge clk);
    check_value(wb_req.cyc, 0, "cyc during reset");
    check_value(wb_req.stb, 0, "stb during reset");
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    check_value(wb_req.cyc, 1, "cyc after reset");
    check_value(wb_req.stb, 1, "stb after reset");
    check_value(wb_req.adr, RESET_PC, "first fetch address");
    check_value(out_valid, 0, "out_valid after reset");
    plain_stream();
    compressed_pairs();
    straddle_join();
    redirect_paths();
    backpressure_order();
    flush_restart();
    $display("Verification passed");
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + TOTAL_ITEMS * 40) @(posedge clk);
    $display("Timeout: the expected instructions did not arrive in time");
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== sim/imem_model.sv ====
`timescale 1ns/1ns

module imem_model import fetch_pkg::*; #(
  parameter int WORDS = 1024
) (
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  localparam int AW = $clog2(WORDS);

  logic [XLEN-1:0] mem [WORDS];  // Loaded by the testbench
  logic [1:0]      wait_left;
  logic [AW-1:0]   index;
  integer          seed = 32'h30e7_2a3f;

  assign index = wb_req.adr[AW+1:2];

  always @(posedge clk) begin
    if (rst) begin
      wb_rsp    <= '0;
      wait_left <= '0;
    end else begin
      wb_rsp.ack <= 1'b0;
      // One ack per cycle, then the master drops cyc
      if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
        if (wait_left == '0) begin
          wb_rsp.ack <= 1'b1;
          wb_rsp.dat <= mem[index];
          wait_left  <= 2'($random(seed));  // Wait states of the next access
        end else begin
          wait_left <= wait_left - 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  output wb_req_t         wb_req,
  input  wb_rsp_t         wb_rsp,
  input  logic            predict_taken,
  input  logic            flush,
  input  logic [XLEN-1:0] flush_pc,
  output logic            out_valid,
  output fetch_item_t     out_item,
  input  logic            out_ready
);

  redirect_t       redirect;
  logic            word_valid;
  logic [XLEN-1:0] word_data;
  logic [XLEN-1:0] word_pc;
  logic            word_free;
  logic            clear;
  logic            queue_full;
  logic            emit_valid;
  fetch_item_t     emit_item;

  fetch_ctrl fetch_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .redirect   (redirect),
    .flush      (flush),
    .flush_pc   (flush_pc),
    .word_free  (word_free),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_pc    (word_pc),
    .clear      (clear)
  );

  parcel_aligner parcel_aligner_i (
    .clk           (clk),
    .rst           (rst),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_pc       (word_pc),
    .word_free     (word_free),
    .clear         (clear),
    .predict_taken (predict_taken),
    .queue_full    (queue_full),
    .emit_valid    (emit_valid),
    .emit_item     (emit_item)
  );

  target_calc target_calc_i (
    .emit_valid (emit_valid),
    .emit_item  (emit_item),
    .redirect   (redirect)
  );

  // Only flush empties the queue
  fetch_queue fetch_queue_i (
    .clk       (clk),
    .rst       (rst),
    .push      (emit_valid),
    .push_item (emit_item),
    .full      (queue_full),
    .flush     (flush),
    .out_valid (out_valid),
    .out_item  (out_item),
    .out_ready (out_ready)
  );

endmodule

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  output wb_req_t         wb_req,
  input  wb_rsp_t         wb_rsp,
  input  redirect_t       redirect,
  input  logic            flush,
  input  logic [XLEN-1:0] flush_pc,
  input  logic            word_free,
  output logic            word_valid,
  output logic [XLEN-1:0] word_data,
  output logic [XLEN-1:0] word_pc,
  output logic            clear
);

  logic            busy;     // Bus cycle in flight
  logic            discard;  // In-flight word is stale
  logic            ack;
  logic            start;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-3:0] adr;

  assign ack        = busy && wb_rsp.ack;
  assign start      = !busy && word_free;
  assign clear      = flush || redirect.valid;
  assign word_valid = ack && !discard && !clear;
  assign word_data  = wb_rsp.dat;
  assign word_pc    = pc;

  assign wb_req.cyc = busy;
  assign wb_req.stb = busy;
  assign wb_req.adr = {adr, 2'b00};

  always_comb begin
    if (flush) begin
      pc_next = flush_pc;
    end else if (redirect.valid) begin
      pc_next = redirect.target;
    end else if (word_valid) begin
      pc_next = {pc[XLEN-1:2] + 1'b1, 2'b00};  // Next word, realigned
    end else begin
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= RESET_PC;
      busy    <= 1'b0;
      discard <= 1'b0;
    end else begin
      pc <= pc_next;
      if (ack) begin
        busy    <= 1'b0;
        discard <= 1'b0;
      end else if (busy) begin
        if (clear) begin
          discard <= 1'b1;
        end
      end else if (start) begin
        busy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      adr <= pc_next[XLEN-1:2];  // Already the redirect target
    end
  end

  // Bus released in the cycle after the ack
  drop_after_ack: assert property (@(posedge clk) disable iff (rst)
    wb_req.cyc && wb_rsp.ack |=> !wb_req.cyc && !wb_req.stb);

  // Request stays put until the slave acks
  req_held: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr));

endmodule

// ==== logic/fetch_queue.sv ====
`timescale 1ns/1ns

module fetch_queue import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        push,
  input  fetch_item_t push_item,
  output logic        full,
  input  logic        flush,
  output logic        out_valid,
  output fetch_item_t out_item,
  input  logic        out_ready
);

  fetch_item_t       mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] head;
  logic [QPTR_W-1:0] tail;
  logic [QPTR_W:0]   count;
  logic              wr;
  logic              pop;

  assign full      = count == (QPTR_W + 1)'(QUEUE_DEPTH);
  assign out_valid = count != '0;
  assign out_item  = mem[head];
  assign wr        = push && !full;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (wr) begin
        tail <= tail + 1'b1;  // Depth is a power of two
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({wr, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[tail] <= push_item;
    end
  end

  // Aligner holds off while full
  no_push_full: assert property (@(posedge clk) disable iff (rst)
    push |-> !full);

endmodule

// ==== logic/target_calc.sv ====
`timescale 1ns/1ns

module target_calc import fetch_pkg::*; (
  input  logic        emit_valid,
  input  fetch_item_t emit_item,
  output redirect_t   redirect
);

  logic [6:0]      opcode;
  logic [XLEN-1:0] j_imm;
  logic [XLEN-1:0] b_imm;
  logic            is_jal;
  logic            is_taken_br;

  assign opcode = emit_item.instr[6:0];

  assign j_imm = {{12{emit_item.instr[31]}}, emit_item.instr[19:12], emit_item.instr[20],
                  emit_item.instr[30:21], 1'b0};
  assign b_imm = {{20{emit_item.instr[31]}}, emit_item.instr[7], emit_item.instr[30:25],
                  emit_item.instr[11:8], 1'b0};

  assign is_jal      = emit_valid && opcode == OPC_JAL;
  assign is_taken_br = emit_valid && opcode == OPC_BRANCH && emit_item.pred_taken;

  assign redirect.valid  = is_jal || is_taken_br;
  assign redirect.target = emit_item.pc + (is_jal ? j_imm : b_imm);

endmodule

// ==== logic/parcel_aligner.sv ====
`timescale 1ns/1ns

module parcel_aligner import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            word_valid,
  input  logic [XLEN-1:0] word_data,
  input  logic [XLEN-1:0] word_pc,
  output logic            word_free,
  input  logic            clear,
  input  logic            predict_taken,
  input  logic            queue_full,
  output logic            emit_valid,
  output fetch_item_t     emit_item
);

  logic                buf_valid;
  logic [XLEN-1:0]     buf_word;
  logic [XLEN-3:0]     buf_adr;      // Word address of buf_word
  logic                idx;          // Next parcel in the buffer
  logic                carry_valid;
  logic [PARCEL_W-1:0] carry_half;
  logic [XLEN-1:0]     carry_pc;
  logic [PARCEL_W-1:0] parcel;
  logic [XLEN-1:0]     parcel_exp;
  logic                is_rvc;
  logic                step;
  logic                start_carry;
  logic [XLEN-1:0]     instr;

  rvc_expander rvc_expander_i (
    .parcel   (parcel),
    .expanded (parcel_exp)
  );

  assign parcel      = idx ? buf_word[XLEN-1:PARCEL_W] : buf_word[PARCEL_W-1:0];
  assign is_rvc      = parcel[1:0] != 2'b11;
  assign step        = buf_valid && !queue_full;
  assign start_carry = !carry_valid && idx && !is_rvc;  // Lower half only
  assign emit_valid  = step && !start_carry;
  assign word_free   = !buf_valid;

  always_comb begin
    if (carry_valid) begin
      instr                = {buf_word[PARCEL_W-1:0], carry_half};
      emit_item.pc         = carry_pc;
      emit_item.compressed = 1'b0;
    end else if (is_rvc) begin
      instr                = parcel_exp;
      emit_item.pc         = {buf_adr, idx, 1'b0};
      emit_item.compressed = 1'b1;
    end else begin
      instr                = buf_word;
      emit_item.pc         = {buf_adr, 2'b00};
      emit_item.compressed = 1'b0;
    end
    emit_item.instr      = instr;
    emit_item.pred_taken = predict_taken && instr[6:0] == OPC_BRANCH;
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      buf_valid   <= 1'b0;
      carry_valid <= 1'b0;
      idx         <= 1'b0;
    end else if (word_valid) begin
      buf_valid <= 1'b1;
      idx       <= word_pc[1];  // Odd target skips the first parcel
    end else if (step) begin
      if (carry_valid) begin
        carry_valid <= 1'b0;
        idx         <= 1'b1;
      end else if (!idx && is_rvc) begin
        idx <= 1'b1;
      end else begin
        buf_valid   <= 1'b0;
        carry_valid <= start_carry;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word_valid) begin
      buf_word <= word_data;
      buf_adr  <= word_pc[XLEN-1:2];
    end
    if (step && start_carry) begin
      carry_half <= parcel;
      carry_pc   <= {buf_adr, 2'b10};
    end
  end

  // Full queue freezes the buffer
  hold_while_full: assert property (@(posedge clk) disable iff (rst)
    buf_valid && queue_full && !clear |=>
      buf_valid && $stable(idx) && $stable(carry_valid));

  // Control only delivers a word into an empty buffer
  load_into_empty: assert property (@(posedge clk) disable iff (rst)
    word_valid |-> !buf_valid);

endmodule

// ==== rvc/rvc_expander.sv ====
`timescale 1ns/1ns

module rvc_expander import fetch_pkg::*; (
  input  logic [PARCEL_W-1:0] parcel,
  output logic [XLEN-1:0]     expanded
);

  logic [PARCEL_W-1:0] c;
  logic [4:0]          rd;
  logic [4:0]          rs2;
  logic [4:0]          rd_p;   // x8 to x15
  logic [4:0]          rs1_p;
  logic [19:0]         j_imm;  // Bits 31:12 of the JAL word
  logic [6:0]          b_hi;
  logic [4:0]          b_lo;

  assign c     = parcel;
  assign rd    = c[11:7];
  assign rs2   = c[6:2];
  assign rd_p  = {2'b01, c[4:2]};
  assign rs1_p = {2'b01, c[9:7]};
  assign j_imm = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}}};
  assign b_hi  = {{4{c[12]}}, c[6:5], c[2]};
  assign b_lo  = {c[11:10], c[4:3], c[12]};

  always_comb begin
    expanded = '0;
    case (c[1:0])
      2'b00: begin
        case (c[15:13])
          3'b000: begin  // ADDI4SPN
            if (c[12:5] != '0) begin
              expanded = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                          5'd2, 3'b000, rd_p, OPC_OP_IMM};
            end
          end
          3'b010: expanded = {5'b0, c[5], c[12:10], c[6], 2'b00,
                              rs1_p, 3'b010, rd_p, OPC_LOAD};
          3'b110: expanded = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010,
                              c[11:10], c[6], 2'b00, OPC_STORE};
          default: expanded = '0;
        endcase
      end
      2'b01: begin
        case (c[15:13])
          3'b000: expanded = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, OPC_OP_IMM};
          3'b001: expanded = {j_imm, 5'd1, OPC_JAL};
          3'b010: expanded = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, OPC_OP_IMM};
          3'b011: begin
            if (rd == 5'd2) begin  // ADDI16SP
              expanded = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                          5'd2, 3'b000, 5'd2, OPC_OP_IMM};
            end else if ({c[12], c[6:2]} != '0) begin
              expanded = {{15{c[12]}}, c[6:2], rd, OPC_LUI};
            end
          end
          3'b100: begin
            case (c[11:10])
              2'b00: expanded = {7'b0000000, c[6:2], rs1_p, 3'b101, rs1_p, OPC_OP_IMM};
              2'b01: expanded = {7'b0100000, c[6:2], rs1_p, 3'b101, rs1_p, OPC_OP_IMM};
              2'b10: expanded = {{7{c[12]}}, c[6:2], rs1_p, 3'b111, rs1_p, OPC_OP_IMM};
              default: begin
                if (!c[12]) begin
                  case (c[6:5])
                    2'b00: expanded = {7'b0100000, rd_p, rs1_p, 3'b000, rs1_p, OPC_OP};
                    2'b01: expanded = {7'b0000000, rd_p, rs1_p, 3'b100, rs1_p, OPC_OP};
                    2'b10: expanded = {7'b0000000, rd_p, rs1_p, 3'b110, rs1_p, OPC_OP};
                    default: expanded = {7'b0000000, rd_p, rs1_p, 3'b111, rs1_p, OPC_OP};
                  endcase
                end
              end
            endcase
          end
          3'b101: expanded = {j_imm, 5'd0, OPC_JAL};
          3'b110: expanded = {b_hi, 5'd0, rs1_p, 3'b000, b_lo, OPC_BRANCH};
          default: expanded = {b_hi, 5'd0, rs1_p, 3'b001, b_lo, OPC_BRANCH};
        endcase
      end
      2'b10: begin
        case (c[15:13])
          3'b000: expanded = {7'b0000000, c[6:2], rd, 3'b001, rd, OPC_OP_IMM};
          3'b010: expanded = {4'b0000, c[3:2], c[12], c[6:4], 2'b00,
                              5'd2, 3'b010, rd, OPC_LOAD};
          3'b100: begin
            if (rs2 != '0) begin  // MV and ADD
              expanded = {7'b0000000, rs2, c[12] ? rd : 5'd0, 3'b000, rd, OPC_OP};
            end else if (rd != '0) begin  // JR and JALR
              expanded = {12'b0, rd, 3'b000, 4'b0000, c[12], OPC_JALR};
            end
          end
          3'b110: expanded = {4'b0000, c[8:7], c[12], rs2, 5'd2, 3'b010,
                              c[11:9], 2'b00, OPC_STORE};
          default: expanded = '0;
        endcase
      end
      default: expanded = '0;  // Not compressed
    endcase
  end

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

  localparam int XLEN        = 32;
  localparam int PARCEL_W    = 16;
  localparam int QUEUE_DEPTH = 8;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Wishbone classic, read only
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [XLEN-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] instr;       // Always the 32-bit form
    logic [XLEN-1:0] pc;
    logic            compressed;
    logic            pred_taken;
  } fetch_item_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage
